// ==== include/stream_proc_settings.svh ====
// ----------------------------------------------------------------------
// Width and depth defines for the stream processor
// ----------------------------------------------------------------------

`ifndef STREAM_PROC_SETTINGS_SVH
`define STREAM_PROC_SETTINGS_SVH

// Operand and result width
`define STREAM_DATA_NBITS 16

// Opcode field width
`define STREAM_OP_NBITS 2

// Queue depths, input side and output side
`define STREAM_IN_DEPTH 4
`define STREAM_OUT_DEPTH 2

`endif

// ==== design/queue_pkg.sv ====
// ----------------------------------------------------------------------
// Queue behavior types
// ----------------------------------------------------------------------

package queue_pkg;

  // Static queue behavior
  // NORMAL  registered in both directions
  // PIPE    enq_rdy follows deq_rdy when full
  // BYPASS  deq_val follows enq_val when empty
  typedef enum logic [1:0] {
    QUEUE_NORMAL = 2'd0,
    QUEUE_PIPE   = 2'd1,
    QUEUE_BYPASS = 2'd2
  } queue_mode_e;

endpackage

// ==== design/stream_pkg.sv ====
// ----------------------------------------------------------------------
// Opcode enum and operand message type
// ----------------------------------------------------------------------

`include "stream_proc_settings.svh"

package stream_pkg;

  // ALU opcodes, all modulo 2^DATA_NBITS
  typedef enum logic [`STREAM_OP_NBITS-1:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_MAX
  } stream_op_e;

  // Operand message, op in the top bits
  typedef struct packed {
    stream_op_e                   op;
    logic [`STREAM_DATA_NBITS-1:0] a;
    logic [`STREAM_DATA_NBITS-1:0] b;
  } stream_msg_t;

endpackage

// ==== design/queue_store_if.sv ====
// ----------------------------------------------------------------------
// Control link from queue control to queue storage
// ----------------------------------------------------------------------

`timescale 1ns/1ps

interface queue_store_if #(
  parameter int addr_nbits = 1
);

  logic                  write_en;
  logic [addr_nbits-1:0] write_addr;
  logic [addr_nbits-1:0] read_addr;
  // High while the queue is empty
  logic                  bypass_sel;

  modport ctrl (output write_en, write_addr, read_addr, bypass_sel);
  modport store (input write_en, write_addr, read_addr, bypass_sel);

endinterface

// ==== design/queue_ctrl.sv ====
// ----------------------------------------------------------------------
// Queue control: pointers, full flag, handshake and free-entry count
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module queue_ctrl
  import queue_pkg::*;
#(
  parameter queue_mode_e mode       = QUEUE_NORMAL,
  parameter int          num_msgs   = 2,
  localparam int         addr_nbits = $clog2(num_msgs)
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                enq_val,
  output logic                enq_rdy,
  output logic                deq_val,
  input  logic                deq_rdy,
  queue_store_if.ctrl         store,
  output logic [addr_nbits:0] num_free_entries
);

  localparam logic pipe_en   = (mode == QUEUE_PIPE);
  localparam logic bypass_en = (mode == QUEUE_BYPASS);
  // Highest storage address, pointers wrap after it
  localparam logic [addr_nbits-1:0] last_addr = addr_nbits'(num_msgs - 1);
  localparam logic [addr_nbits:0]   max_count = (addr_nbits + 1)'(num_msgs);

  logic [addr_nbits-1:0] enq_ptr;
  logic [addr_nbits-1:0] deq_ptr;
  logic [addr_nbits-1:0] enq_ptr_inc;
  logic [addr_nbits-1:0] deq_ptr_inc;
  logic                  full;
  logic                  empty;
  logic                  do_enq;
  logic                  do_deq;
  logic                  do_pipe;
  logic                  do_bypass;
  logic [addr_nbits:0]   used;

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------

  // Equal pointers mean empty unless the full flag is set
  assign empty = !full && (enq_ptr == deq_ptr);

  // Pipe: a full queue accepts when the consumer takes the head
  assign enq_rdy = !full || (pipe_en && deq_rdy);
  // Bypass: an empty queue offers the incoming message directly
  assign deq_val = !empty || (bypass_en && enq_val);

  assign do_enq    = enq_val && enq_rdy;
  assign do_deq    = deq_val && deq_rdy;
  assign do_pipe   = pipe_en && full && do_enq && do_deq;
  // Message goes straight through, storage untouched
  assign do_bypass = bypass_en && empty && do_enq && do_deq;

  // Storage controls
  assign store.write_en   = do_enq && !do_bypass;
  assign store.write_addr = enq_ptr;
  assign store.read_addr  = deq_ptr;
  assign store.bypass_sel = empty;

  // ----------------------------------------------------------------------
  // Pointers and full flag
  // ----------------------------------------------------------------------

  assign enq_ptr_inc = (enq_ptr == last_addr) ? '0 : enq_ptr + 1'b1;
  assign deq_ptr_inc = (deq_ptr == last_addr) ? '0 : deq_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      enq_ptr <= '0;
      deq_ptr <= '0;
      full    <= 1'b0;
    end else begin
      if (do_enq && !do_bypass) begin
        enq_ptr <= enq_ptr_inc;
      end
      if (do_deq && !do_bypass) begin
        deq_ptr <= deq_ptr_inc;
      end
      // Last free slot taken with nothing leaving
      if (do_enq && !do_deq && (enq_ptr_inc == deq_ptr)) begin
        full <= 1'b1;
      end else if (do_deq && !do_pipe) begin
        full <= 1'b0;
      end
    end
  end

  // Occupied entries from the pointer distance
  always_comb begin
    if (full) begin
      used = max_count;
    end else if (enq_ptr >= deq_ptr) begin
      used = {1'b0, enq_ptr - deq_ptr};
    end else begin
      used = max_count - {1'b0, deq_ptr - enq_ptr};
    end
  end

  assign num_free_entries = max_count - used;

endmodule

// ==== design/queue_dpath.sv ====
// ----------------------------------------------------------------------
// Queue storage array with optional bypass mux
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module queue_dpath
  import queue_pkg::*;
#(
  parameter queue_mode_e mode      = QUEUE_NORMAL,
  parameter int          msg_nbits = 1,
  parameter int          num_msgs  = 2
) (
  input  logic                 clk,
  queue_store_if.store         store,
  input  logic [msg_nbits-1:0] enq_msg,
  output logic [msg_nbits-1:0] deq_msg
);

  localparam logic bypass_en = (mode == QUEUE_BYPASS);

  // Storage, one entry per message slot
  logic [msg_nbits-1:0] mem [num_msgs];
  logic [msg_nbits-1:0] read_data;

  always_ff @(posedge clk) begin
    if (store.write_en) begin
      mem[store.write_addr] <= enq_msg;
    end
  end

  // Asynchronous read of the head entry
  assign read_data = mem[store.read_addr];

  // ----------------------------------------------------------------------
  // Bypass mux
  // ----------------------------------------------------------------------

  // Only bypass queues forward enq_msg, the mux folds away otherwise
  assign deq_msg = (bypass_en && store.bypass_sel) ? enq_msg : read_data;

endmodule

// ==== design/msg_queue.sv ====
// ----------------------------------------------------------------------
// Valid/ready message queue, control and storage joined
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module msg_queue
  import queue_pkg::*;
#(
  parameter queue_mode_e mode       = QUEUE_NORMAL,
  parameter int          msg_nbits  = 1,
  // Two entries minimum
  parameter int          num_msgs   = 2,
  localparam int         addr_nbits = $clog2(num_msgs)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enq_val,
  output logic                 enq_rdy,
  input  logic [msg_nbits-1:0] enq_msg,
  output logic                 deq_val,
  input  logic                 deq_rdy,
  output logic [msg_nbits-1:0] deq_msg,
  output logic [addr_nbits:0]  num_free_entries
);

  // Write and read controls between the two halves
  queue_store_if #(.addr_nbits(addr_nbits)) store_if ();

  queue_ctrl #(
    .mode    (mode),
    .num_msgs(num_msgs)
  ) u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .enq_val         (enq_val),
    .enq_rdy         (enq_rdy),
    .deq_val         (deq_val),
    .deq_rdy         (deq_rdy),
    .store           (store_if),
    .num_free_entries(num_free_entries)
  );

  queue_dpath #(
    .mode     (mode),
    .msg_nbits(msg_nbits),
    .num_msgs (num_msgs)
  ) u_dpath (
    .clk    (clk),
    .store  (store_if),
    .enq_msg(enq_msg),
    .deq_msg(deq_msg)
  );

endmodule

// ==== design/stream_alu.sv ====
// ----------------------------------------------------------------------
// One-entry registered ALU stage, valid/ready on both sides
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "stream_proc_settings.svh"

module stream_alu
  import stream_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_val,
  output logic                          in_rdy,
  input  stream_msg_t                   in_msg,
  output logic                          out_val,
  input  logic                          out_rdy,
  output logic [`STREAM_DATA_NBITS-1:0] out_data
);

  logic [`STREAM_DATA_NBITS-1:0] result;

  // ----------------------------------------------------------------------
  // Arithmetic
  // ----------------------------------------------------------------------

  always_comb begin
    case (in_msg.op)
      OP_ADD:  result = in_msg.a + in_msg.b;
      OP_SUB:  result = in_msg.a - in_msg.b;
      OP_XOR:  result = in_msg.a ^ in_msg.b;
      // Unsigned compare, ties give a
      OP_MAX:  result = (in_msg.a >= in_msg.b) ? in_msg.a : in_msg.b;
      default: result = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------

  // Take a new message when empty or when the held result leaves now
  assign in_rdy = !out_val || out_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else if (in_rdy) begin
      out_val <= in_val;
    end
  end

  // Result held while stalled
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      out_data <= result;
    end
  end

endmodule

// ==== design/stream_proc_top.sv ====
// ----------------------------------------------------------------------
// Stream processor top: input queue, ALU stage, output queue
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "stream_proc_settings.svh"

module stream_proc_top
  import queue_pkg::*;
  import stream_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                in_val,
  output logic                                in_rdy,
  input  logic [`STREAM_OP_NBITS-1:0]         in_op,
  input  logic [`STREAM_DATA_NBITS-1:0]       in_a,
  input  logic [`STREAM_DATA_NBITS-1:0]       in_b,
  output logic                                out_val,
  input  logic                                out_rdy,
  output logic [`STREAM_DATA_NBITS-1:0]       out_data,
  output logic [$clog2(`STREAM_IN_DEPTH):0]   in_free_entries
);

  stream_msg_t                   in_msg;
  stream_msg_t                   alu_in_msg;
  logic                          alu_in_val;
  logic                          alu_in_rdy;
  logic                          alu_out_val;
  logic                          alu_out_rdy;
  logic [`STREAM_DATA_NBITS-1:0] alu_out_data;

  // Pack the operand fields
  assign in_msg = '{op: stream_op_e'(in_op), a: in_a, b: in_b};

  // Pipe mode lets a full input queue accept while the ALU drains it
  msg_queue #(
    .mode     (QUEUE_PIPE),
    .msg_nbits($bits(stream_msg_t)),
    .num_msgs (`STREAM_IN_DEPTH)
  ) u_in_queue (
    .clk             (clk),
    .rst             (rst),
    .enq_val         (in_val),
    .enq_rdy         (in_rdy),
    .enq_msg         (in_msg),
    .deq_val         (alu_in_val),
    .deq_rdy         (alu_in_rdy),
    .deq_msg         (alu_in_msg),
    .num_free_entries(in_free_entries)
  );

  stream_alu u_alu (
    .clk     (clk),
    .rst     (rst),
    .in_val  (alu_in_val),
    .in_rdy  (alu_in_rdy),
    .in_msg  (alu_in_msg),
    .out_val (alu_out_val),
    .out_rdy (alu_out_rdy),
    .out_data(alu_out_data)
  );

  // Bypass mode keeps the total latency at 2 cycles
  // Output-side occupancy is not brought out
  msg_queue #(
    .mode     (QUEUE_BYPASS),
    .msg_nbits(`STREAM_DATA_NBITS),
    .num_msgs (`STREAM_OUT_DEPTH)
  ) u_out_queue (
    .clk             (clk),
    .rst             (rst),
    .enq_val         (alu_out_val),
    .enq_rdy         (alu_out_rdy),
    .enq_msg         (alu_out_data),
    .deq_val         (out_val),
    .deq_rdy         (out_rdy),
    .deq_msg         (out_data),
    .num_free_entries()
  );

endmodule

// ==== verif/stream_proc_assertions.sv ====
// ----------------------------------------------------------------------
// Handshake and reset assertions, bound into the stream processor top
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "stream_proc_settings.svh"

module stream_proc_assertions (
  input logic                          clk,
  input logic                          rst,
  input logic                          in_val,
  input logic                          in_rdy,
  input logic [`STREAM_OP_NBITS-1:0]   in_op,
  input logic [`STREAM_DATA_NBITS-1:0] in_a,
  input logic [`STREAM_DATA_NBITS-1:0] in_b,
  input logic                          out_val,
  input logic                          out_rdy,
  input logic [`STREAM_DATA_NBITS-1:0] out_data
);

  // Stalled input message stays offered and unchanged
  a_in_hold: assert property (
    @(posedge clk) disable iff (rst)
    (in_val && !in_rdy) |=> (in_val && $stable({in_op, in_a, in_b}))
  ) else $error("input message dropped or changed while stalled");

  // Stalled result stays offered and unchanged
  a_out_hold: assert property (
    @(posedge clk) disable iff (rst)
    (out_val && !out_rdy) |=> (out_val && $stable(out_data))
  ) else $error("out_data dropped or changed while stalled");

  // Nothing leaves right after reset
  a_reset_idle: assert property (
    @(posedge clk) rst |=> !out_val
  ) else $error("out_val high in the cycle after reset");

endmodule

bind stream_proc_top stream_proc_assertions u_assertions (
  .clk     (clk),
  .rst     (rst),
  .in_val  (in_val),
  .in_rdy  (in_rdy),
  .in_op   (in_op),
  .in_a    (in_a),
  .in_b    (in_b),
  .out_val (out_val),
  .out_rdy (out_rdy),
  .out_data(out_data)
);

// ==== verif/stream_proc_tb.sv ====
// ----------------------------------------------------------------------
// Stream processor testbench: reset, directed opcodes, latency,
// back-pressure and random stream against a reference model
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "stream_proc_settings.svh"

module stream_proc_tb
  import stream_pkg::*;
();

  localparam int dw             = `STREAM_DATA_NBITS;
  localparam int opw            = `STREAM_OP_NBITS;
  localparam int timeout_cycles = 200;
  localparam int num_random     = 200;

  logic                             clk;
  logic                             rst;
  logic                             in_val;
  logic                             in_rdy;
  logic [opw-1:0]                   in_op;
  logic [dw-1:0]                    in_a;
  logic [dw-1:0]                    in_b;
  logic                             out_val;
  logic                             out_rdy;
  logic [dw-1:0]                    out_data;
  logic [$clog2(`STREAM_IN_DEPTH):0] in_free_entries;

  int            seed      = 45;
  int            errors    = 0;
  int            n_checked = 0;
  int            cycle     = 0;
  logic [dw-1:0] exp_q[$];
  logic [dw-1:0] exp_val;

  stream_proc_top u_stream_proc_top (
    .clk            (clk),
    .rst            (rst),
    .in_val         (in_val),
    .in_rdy         (in_rdy),
    .in_op          (in_op),
    .in_a           (in_a),
    .in_b           (in_b),
    .out_val        (out_val),
    .out_rdy        (out_rdy),
    .out_data       (out_data),
    .in_free_entries(in_free_entries)
  );

  // 8 ns period
  always #4 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // Expected result straight from the opcode rules
  function automatic logic [dw-1:0] ref_result(input logic [opw-1:0] op,
                                               input logic [dw-1:0]  a,
                                               input logic [dw-1:0]  b);
    logic [dw-1:0] r;
    case (stream_op_e'(op))
      // Carry falls off the 16-bit result
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_XOR:  r = a ^ b;
      OP_MAX:  r = (a > b) ? a : b;
      default: r = '0;
    endcase
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // Output comparison
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst && out_val && out_rdy) begin
      assert (exp_q.size() != 0) else begin
        $display("Output transfer with no expected result pending");
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp_val = exp_q.pop_front();
        n_checked++;
        assert (out_data == exp_val) else begin
          $display("** Error out_data: expected %h, got %h", exp_val, out_data);
          errors++;
        end
      end
    end
  end

  task automatic check_equal(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("** Error %s: expected %0h, got %0h", name, expected, actual);
      errors++;
    end
  endtask

  // Offer one message and hold it until taken, returns 1 ns after that edge
  task automatic send_msg(input logic [opw-1:0] op, input logic [dw-1:0] a,
                          input logic [dw-1:0] b, output int accept_cycle);
    int waits;
    waits        = 0;
    accept_cycle = -1;
    in_val       = 1'b1;
    in_op        = op;
    in_a         = a;
    in_b         = b;
    @(posedge clk);
    while (!in_rdy && waits < timeout_cycles) begin
      waits++;
      @(posedge clk);
    end
    assert (in_rdy) else begin
      $display("Timeout: input message not accepted within %0d cycles", timeout_cycles);
      errors++;
    end
    if (in_rdy) begin
      exp_q.push_back(ref_result(op, a, b));
      accept_cycle = cycle;
    end
    #1;
    in_val = 1'b0;
  endtask

  // Wait until every expected result came out, sampled on the falling edge
  task automatic wait_drained();
    int waits;
    waits = 0;
    while (exp_q.size() != 0 && waits < timeout_cycles) begin
      waits++;
      @(negedge clk);
    end
    assert (exp_q.size() == 0) else begin
      $display("Timeout: %0d expected results never came out", exp_q.size());
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    int acc;
    int waits;
    int sent;
    int mark;
    int i;
    bit taken;
    clk     = 1'b0;
    rst     = 1'b1;
    in_val  = 1'b0;
    in_op   = '0;
    in_a    = '0;
    in_b    = '0;
    out_rdy = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset state
    mark = errors;
    check_equal("out_val", 0, int'(out_val));
    check_equal("in_rdy", 1, int'(in_rdy));
    check_equal("in_free_entries", 4, int'(in_free_entries));
    report_test("reset", mark);

    // One message per opcode with the wrap and tie cases
    mark    = errors;
    out_rdy = 1'b1;
    send_msg(OP_ADD, 16'hffff, 16'h0002, acc);
    send_msg(OP_SUB, 16'h0003, 16'h0005, acc);
    send_msg(OP_XOR, 16'ha5a5, 16'h0ff0, acc);
    send_msg(OP_MAX, 16'h1234, 16'h1234, acc);
    send_msg(OP_MAX, 16'h0001, 16'h8000, acc);
    wait_drained();
    report_test("opcodes", mark);

    // Idle pipe, result must show two edges after acceptance
    mark  = errors;
    waits = 0;
    send_msg(OP_XOR, 16'h1234, 16'h00ff, acc);
    @(posedge clk);
    while (!out_val && waits < timeout_cycles) begin
      waits++;
      @(posedge clk);
    end
    assert (out_val) else begin
      $display("Timeout: out_val never rose after a single message");
      errors++;
    end
    check_equal("latency", 2, cycle - acc);
    #1;
    wait_drained();
    report_test("latency", mark);

    // Seven messages fill output queue, ALU and input queue
    mark    = errors;
    out_rdy = 1'b0;
    for (i = 0; i < 7; i++) begin
      check_equal("in_rdy", 1, int'(in_rdy));
      send_msg(opw'($random(seed)), dw'($random(seed)), dw'($random(seed)), acc);
    end
    check_equal("in_free_entries", 0, int'(in_free_entries));
    repeat (4) begin
      check_equal("in_rdy", 0, int'(in_rdy));
      @(posedge clk);
      #1;
    end
    out_rdy = 1'b1;
    wait_drained();
    report_test("backpressure", mark);

    // Random stream with input gaps and output stalls
    mark  = errors;
    sent  = 0;
    waits = 0;
    while (sent < num_random && waits < timeout_cycles) begin
      if (!in_val && (($random(seed) & 3) != 0)) begin
        in_val = 1'b1;
        in_op  = opw'($random(seed));
        in_a   = dw'($random(seed));
        in_b   = dw'($random(seed));
      end
      out_rdy = (($random(seed) & 3) != 0);
      @(posedge clk);
      taken = in_val && in_rdy;
      if (taken) begin
        exp_q.push_back(ref_result(in_op, in_a, in_b));
        sent++;
        waits = 0;
      end else begin
        waits++;
      end
      #1;
      if (taken) begin
        in_val = 1'b0;
      end
    end
    in_val = 1'b0;
    assert (sent == num_random) else begin
      $display("Timeout: random stream stalled after %0d messages", sent);
      errors++;
    end
    out_rdy = 1'b1;
    wait_drained();
    report_test("random", mark);

    $display("Summary: %0d results checked, %0d errors", n_checked, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== stream_proc_top.f ====
+incdir+include
design/queue_pkg.sv
design/stream_pkg.sv
design/queue_store_if.sv
design/queue_ctrl.sv
design/queue_dpath.sv
design/msg_queue.sv
design/stream_alu.sv
design/stream_proc_top.sv
verif/stream_proc_assertions.sv
verif/stream_proc_tb.sv

// ==== Makefile ====
# Verilator build and run for the stream processor testbench
# Override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= stream_proc_tb
FILELIST  ?= stream_proc_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***
BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv verif/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF -- '$(FAIL_MSG)' $(LOG) || ! grep -qF -- '$(PASS_MSG)' $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
